/* include/ex_defines.svh */
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// alu operation codes
`define ALU_ADD 3'd2
`define ALU_SUB 3'd3
`define ALU_AND 3'd4
`define ALU_OR  3'd5
`define ALU_NOR 3'd6
`define ALU_XOR 3'd7

// second operand source
`define SRC2_REG      2'd0
`define SRC2_SIGN_IMM 2'd1
`define SRC2_ZERO_IMM 2'd2

// upper-half move on the shifter path
`define PLUS32_NONE  2'd0
`define PLUS32_LEFT  2'd1 // low half up, zero fill below
`define PLUS32_RIGHT 2'd2 // high half down, zero fill above

`endif

/* verilog/ex_pkg.sv */
package ex_pkg;

    // datapath word, also used for pc4 and store data
    typedef logic [63:0] word_t;

    typedef logic [31:0] inst_t;

    typedef logic [4:0] reg_num_t; // gpr index

    typedef logic [2:0] alu_op_t;

    // operand and result selectors
    typedef logic [1:0] src2_sel_t;
    typedef logic [1:0] plus32_sel_t;

    // cp0 select field, inst[2:0]
    typedef logic [2:0] mem_sel_t;

endpackage

/* verilog/alu.sv */
`timescale 1ns/1ps

`include "ex_defines.svh"

module alu
    import ex_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t alu_op,
    output word_t   result,
    output logic    overflow,
    output logic    zero,
    output logic    negative
);

    word_t sum;
    word_t diff;
    logic  add_ov;
    logic  sub_ov;

    assign sum  = a + b;
    assign diff = a - b;

    // same-sign inputs giving a result of the other sign
    assign add_ov = (a[63] == b[63]) && (sum[63] != a[63]);
    // operands of different sign, result takes the sign of b
    assign sub_ov = (a[63] != b[63]) && (diff[63] != a[63]);

    always_comb begin
        case (alu_op)
            `ALU_ADD: begin
                result   = sum;
                overflow = add_ov;
            end
            `ALU_SUB: begin
                result   = diff;
                overflow = sub_ov;
            end
            `ALU_AND: begin
                result   = a & b;
                overflow = 1'b0;
            end
            `ALU_OR: begin
                result   = a | b;
                overflow = 1'b0;
            end
            `ALU_NOR: begin
                result   = ~(a | b);
                overflow = 1'b0;
            end
            `ALU_XOR: begin
                result   = a ^ b;
                overflow = 1'b0;
            end
            default: begin
                result   = '0; // codes 0 and 1 are not used by decode
                overflow = 1'b0;
            end
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[63];

endmodule

/* verilog/barrel_shifter.sv */
`timescale 1ns/1ps

module barrel_shifter
    import ex_pkg::*;
(
    input  word_t      data,
    input  logic [4:0] shamt,
    input  logic       shift_right,
    output word_t      result
);

    word_t lvl0;
    word_t lvl1;
    word_t lvl2;
    word_t lvl3;
    word_t lvl4;
    word_t lvl5;

    function automatic word_t bit_reverse(input word_t v);
        word_t r;
        for (int i = 0; i < 64; i++) begin
            r[i] = v[63 - i];
        end
        return r;
    endfunction

    // right shifts run through the same left levels on a mirrored word
    assign lvl0 = shift_right ? bit_reverse(data) : data;

    assign lvl1 = shamt[0] ? {lvl0[62:0], 1'b0}  : lvl0;
    assign lvl2 = shamt[1] ? {lvl1[61:0], 2'b0}  : lvl1;
    assign lvl3 = shamt[2] ? {lvl2[59:0], 4'b0}  : lvl2;
    assign lvl4 = shamt[3] ? {lvl3[55:0], 8'b0}  : lvl3;
    assign lvl5 = shamt[4] ? {lvl4[47:0], 16'b0} : lvl4;

    assign result = shift_right ? bit_reverse(lvl5) : lvl5;

endmodule

/* verilog/core_ex.sv */
`timescale 1ns/1ps

`include "ex_defines.svh"

module core_ex
    import ex_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        stall,
    input  logic        flush,
    input  logic        d_valid,
    input  inst_t       inst,
    input  word_t       a_data,
    input  word_t       b_data,
    input  word_t       pc4,
    input  alu_op_t     alu_op,
    input  src2_sel_t   alu_src2,
    input  logic        slt,
    input  logic        cut_alu_out32,
    input  logic        cut_shifter_out32,
    input  logic        shift_right,
    input  plus32_sel_t shifter_plus32,
    input  logic        alu_shifter_src,
    input  logic        rd_src,
    input  logic        mem_read,
    input  logic        word_we,
    input  logic        byte_we,
    input  logic        byte_load,
    input  logic        write_enable,
    input  logic        mfc0,
    input  logic        mtc0,
    input  logic        eret,
    input  logic        reserved_inst,
    output word_t       ex_out,
    output word_t       ex_b_data,
    output word_t       ex_pc4,
    output reg_num_t    ex_w_regnum,
    output mem_sel_t    ex_sel,
    output logic        ex_overflow,
    output logic        ex_zero,
    output logic        ex_mem_read,
    output logic        ex_word_we,
    output logic        ex_byte_we,
    output logic        ex_byte_load,
    output logic        ex_write_enable,
    output logic        ex_mfc0,
    output logic        ex_mtc0,
    output logic        ex_eret,
    output logic        ex_reserved_inst
);

    word_t    sign_imm;
    word_t    zero_imm;
    word_t    src2;
    word_t    alu_raw;
    word_t    alu_res;
    word_t    shift_raw;
    word_t    shift_cut;
    word_t    shift_res;
    word_t    stage_out;
    logic     alu_ov;
    logic     alu_zero;
    logic     alu_neg;
    logic     slt_bit;
    reg_num_t w_regnum;

    assign sign_imm = {{48{inst[15]}}, inst[15:0]};
    assign zero_imm = {48'b0, inst[15:0]};

    always_comb begin
        case (alu_src2)
            `SRC2_SIGN_IMM: src2 = sign_imm;
            `SRC2_ZERO_IMM: src2 = zero_imm;
            default:        src2 = b_data; // SRC2_REG
        endcase
    end

    alu i_alu (
        .a        (a_data),
        .b        (src2),
        .alu_op   (alu_op),
        .result   (alu_raw),
        .overflow (alu_ov),
        .zero     (alu_zero),
        .negative (alu_neg)
    );

    barrel_shifter i_barrel_shifter (
        .data        (b_data),
        .shamt       (inst[10:6]),
        .shift_right (shift_right),
        .result      (shift_raw)
    );

    assign alu_res   = cut_alu_out32 ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;
    assign shift_cut = cut_shifter_out32 ? {{32{shift_raw[31]}}, shift_raw[31:0]} : shift_raw;

    always_comb begin
        case (shifter_plus32)
            `PLUS32_LEFT:  shift_res = {shift_cut[31:0], 32'b0};
            `PLUS32_RIGHT: shift_res = {32'b0, shift_cut[63:32]};
            default:       shift_res = shift_cut;
        endcase
    end

    // decode pairs slt with ALU_SUB, so alu_neg is the sign of a - src2;
    // with equal signs the subtraction cannot overflow
    assign slt_bit = (a_data[63] & ~src2[63]) | ((a_data[63] == src2[63]) & alu_neg);

    always_comb begin
        if (slt) begin
            stage_out = {63'b0, slt_bit};
        end else begin
            stage_out = alu_shifter_src ? shift_res : alu_res;
        end
    end

    assign w_regnum = rd_src ? inst[20:16] : inst[15:11];

    // EX/MEM register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ex_out           <= '0;
            ex_b_data        <= '0;
            ex_pc4           <= '0;
            ex_w_regnum      <= '0;
            ex_sel           <= '0;
            ex_overflow      <= 1'b0;
            ex_zero          <= 1'b0;
            ex_mem_read      <= 1'b0;
            ex_word_we       <= 1'b0;
            ex_byte_we       <= 1'b0;
            ex_byte_load     <= 1'b0;
            ex_write_enable  <= 1'b0;
            ex_mfc0          <= 1'b0;
            ex_mtc0          <= 1'b0;
            ex_eret          <= 1'b0;
            ex_reserved_inst <= 1'b0;
        end else if (flush) begin
            ex_out           <= '0;
            ex_b_data        <= '0;
            ex_pc4           <= '0;
            ex_w_regnum      <= '0;
            ex_sel           <= '0;
            ex_overflow      <= 1'b0;
            ex_zero          <= 1'b0;
            ex_mem_read      <= 1'b0;
            ex_word_we       <= 1'b0;
            ex_byte_we       <= 1'b0;
            ex_byte_load     <= 1'b0;
            ex_write_enable  <= 1'b0;
            ex_mfc0          <= 1'b0;
            ex_mtc0          <= 1'b0;
            ex_eret          <= 1'b0;
            ex_reserved_inst <= 1'b0;
        end else if (stall) begin
            if (!d_valid) begin
                // hold the data, drop anything that would repeat a write
                ex_mem_read     <= 1'b0;
                ex_word_we      <= 1'b0;
                ex_byte_we      <= 1'b0;
                ex_write_enable <= 1'b0;
                ex_mfc0         <= 1'b0;
                ex_mtc0         <= 1'b0;
                ex_eret         <= 1'b0;
                ex_overflow     <= 1'b0;
                ex_zero         <= 1'b0;
            end
        end else begin
            ex_out           <= stage_out;
            ex_b_data        <= b_data;
            ex_pc4           <= pc4;
            ex_w_regnum      <= w_regnum;
            ex_sel           <= inst[2:0];
            ex_overflow      <= alu_ov;
            ex_zero          <= alu_zero;
            ex_mem_read      <= mem_read;
            ex_word_we       <= word_we;
            ex_byte_we       <= byte_we;
            ex_byte_load     <= byte_load;
            ex_write_enable  <= write_enable;
            ex_mfc0          <= mfc0;
            ex_mtc0          <= mtc0;
            ex_eret          <= eret;
            ex_reserved_inst <= reserved_inst;
        end
    end

endmodule

/* dv/core_ex_assert.sv */
`timescale 1ns/1ps

module core_ex_assert
    import ex_pkg::*;
(
    input logic     clock, reset, stall, flush, d_valid,
    input word_t    ex_out, ex_b_data, ex_pc4,
    input reg_num_t ex_w_regnum,
    input logic     ex_mem_read, ex_word_we, ex_byte_we, ex_write_enable
);

    int failures = 0;

    reset_clears: assert property (@(posedge clock)
        reset |-> ex_out == '0 && !ex_write_enable && !ex_mem_read)
    else begin
        failures++;
        $error("register not clear during reset");
    end

    flush_clears: assert property (@(posedge clock) disable iff (reset)
        flush |=> ex_out == '0 && ex_b_data == '0 && ex_pc4 == '0 && ex_w_regnum == '0)
    else begin
        failures++;
        $error("register not clear after flush");
    end

    // data memory ready, so the whole register holds
    valid_stall_holds: assert property (@(posedge clock) disable iff (reset)
        stall && d_valid && !flush |=> $stable(ex_out) && $stable(ex_b_data)
            && $stable(ex_pc4) && $stable(ex_write_enable))
    else begin
        failures++;
        $error("register changed under a valid stall");
    end

    invalid_stall_drops: assert property (@(posedge clock) disable iff (reset)
        stall && !d_valid && !flush |=> !ex_mem_read && !ex_word_we && !ex_byte_we
            && !ex_write_enable)
    else begin
        failures++;
        $error("write enables still set after an invalid stall");
    end

endmodule

/* dv/ex_checker.sv */
`timescale 1ns/1ps

`include "ex_defines.svh"

module ex_checker
    import ex_pkg::*;
(
    input  logic        clock, reset, stall, flush, d_valid,
    input  inst_t       inst,
    input  word_t       a_data, b_data, pc4,
    input  alu_op_t     alu_op,
    input  src2_sel_t   alu_src2,
    input  logic        slt, cut_alu_out32, cut_shifter_out32, shift_right,
    input  plus32_sel_t shifter_plus32,
    input  logic        alu_shifter_src, rd_src,
    input  logic        mem_read, word_we, byte_we, byte_load, write_enable,
    input  logic        mfc0, mtc0, eret, reserved_inst,
    input  word_t       ex_out, ex_b_data, ex_pc4,
    input  reg_num_t    ex_w_regnum,
    input  mem_sel_t    ex_sel,
    input  logic        ex_overflow, ex_zero,
    input  logic        ex_mem_read, ex_word_we, ex_byte_we, ex_byte_load, ex_write_enable,
    input  logic        ex_mfc0, ex_mtc0, ex_eret, ex_reserved_inst,
    output int          checks,
    output int          errors
);

    int          n_checks = 0;
    int          n_errors = 0;
    word_t       exp_out = '0;
    word_t       exp_b_data = '0;
    word_t       exp_pc4 = '0;
    reg_num_t    exp_regnum = '0;
    mem_sel_t    exp_sel = '0;
    logic        exp_ov = 1'b0;
    logic        exp_zero = 1'b0;
    logic [4:0]  exp_mem = '0; // mem_read, word_we, byte_we, byte_load, write_enable
    logic [3:0]  exp_cp0 = '0; // mfc0, mtc0, eret, reserved_inst
    logic [65:0] pred;

    assign checks = n_checks;
    assign errors = n_errors;

    // {overflow, zero, result} for the instruction now on the inputs
    function automatic logic [65:0] predict_result();
        word_t       op2;
        word_t       res;
        word_t       sh;
        logic [64:0] wide;
        logic        ov;
        logic        zf;
        op2 = (alu_src2 == `SRC2_SIGN_IMM) ? 64'($signed(inst[15:0])) :
              (alu_src2 == `SRC2_ZERO_IMM) ? 64'(inst[15:0]) : b_data;
        ov = 1'b0;
        case (alu_op)
            `ALU_ADD: begin
                wide = {a_data[63], a_data} + {op2[63], op2};
                res  = wide[63:0];
                ov   = wide[64] ^ wide[63]; // result does not fit 64 signed bits
            end
            `ALU_SUB: begin
                wide = {a_data[63], a_data} - {op2[63], op2};
                res  = wide[63:0];
                ov   = wide[64] ^ wide[63];
            end
            `ALU_AND: res = a_data & op2;
            `ALU_OR:  res = a_data | op2;
            `ALU_XOR: res = a_data ^ op2;
            `ALU_NOR: res = ~(a_data | op2);
            default:  res = '0;
        endcase
        zf = (res == '0);
        if (cut_alu_out32) res = 64'($signed(res[31:0]));
        sh = shift_right ? (b_data >> inst[10:6]) : (b_data << inst[10:6]);
        if (cut_shifter_out32) sh = 64'($signed(sh[31:0]));
        if (shifter_plus32 == `PLUS32_LEFT) sh = sh << 32;
        else if (shifter_plus32 == `PLUS32_RIGHT) sh = sh >> 32;
        if (alu_shifter_src) res = sh;
        if (slt) res = {63'b0, $signed(a_data) < $signed(op2)};
        return {ov, zf, res};
    endfunction

    task automatic clear_expected();
        {exp_out, exp_b_data, exp_pc4, exp_regnum, exp_sel} = '0;
        {exp_ov, exp_zero, exp_mem, exp_cp0} = '0;
    endtask

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    // outputs have settled by the falling edge and the inputs belong to the next capture
    always @(negedge clock) begin
        if (reset) begin
            clear_expected(); // asynchronous reset clears the register at once
        end
        compare_field("ex_out", ex_out, exp_out);
        compare_field("ex_b_data", ex_b_data, exp_b_data);
        compare_field("ex_pc4", ex_pc4, exp_pc4);
        compare_field("ex_w_regnum", 64'(ex_w_regnum), 64'(exp_regnum));
        compare_field("ex_sel", 64'(ex_sel), 64'(exp_sel));
        compare_field("ex_overflow", 64'(ex_overflow), 64'(exp_ov));
        compare_field("ex_zero", 64'(ex_zero), 64'(exp_zero));
        compare_field("memory controls", 64'({ex_mem_read, ex_word_we, ex_byte_we,
                      ex_byte_load, ex_write_enable}), 64'(exp_mem));
        compare_field("cp0 controls", 64'({ex_mfc0, ex_mtc0, ex_eret, ex_reserved_inst}),
                      64'(exp_cp0));
        pred = predict_result();
        if (reset || flush) begin
            clear_expected();
        end else if (stall) begin
            if (!d_valid) begin
                exp_ov   = 1'b0;
                exp_zero = 1'b0;
                exp_mem  = exp_mem & 5'b00010; // byte_load survives
                exp_cp0  = exp_cp0 & 4'b0001;  // reserved_inst survives
            end
        end else begin
            {exp_ov, exp_zero, exp_out} = pred;
            exp_b_data = b_data;
            exp_pc4    = pc4;
            exp_regnum = rd_src ? inst[20:16] : inst[15:11];
            exp_sel    = inst[2:0];
            exp_mem    = {mem_read, word_we, byte_we, byte_load, write_enable};
            exp_cp0    = {mfc0, mtc0, eret, reserved_inst};
        end
    end

endmodule

/* dv/tb_core_ex.sv */
`timescale 1ns/1ps

`include "ex_defines.svh"

module tb_core_ex
    import ex_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int NUM_CYCLES   = 3000;
    localparam int RESET_AT     = NUM_CYCLES / 2; // stimulus cycle of the second reset
    localparam int MAX_CYCLES   = RESET_CYCLES + NUM_CYCLES + 20;

    logic        clock = 1'b0;
    logic        reset;
    logic        stall, flush, d_valid;
    inst_t       inst;
    word_t       a_data, b_data, pc4;
    alu_op_t     alu_op;
    src2_sel_t   alu_src2;
    logic        slt, cut_alu_out32, cut_shifter_out32, shift_right;
    plus32_sel_t shifter_plus32;
    logic        alu_shifter_src, rd_src;
    logic        mem_read, word_we, byte_we, byte_load, write_enable;
    logic        mfc0, mtc0, eret, reserved_inst;
    word_t       ex_out, ex_b_data, ex_pc4;
    reg_num_t    ex_w_regnum;
    mem_sel_t    ex_sel;
    logic        ex_overflow, ex_zero;
    logic        ex_mem_read, ex_word_we, ex_byte_we, ex_byte_load, ex_write_enable;
    logic        ex_mfc0, ex_mtc0, ex_eret, ex_reserved_inst;
    int          checks;
    int          errors;
    int          seed;
    int          cycles = 0;
    logic        done = 1'b0;

    always #50 clock = ~clock;

    core_ex i_core_ex (.*);

    ex_checker i_ex_checker (.*);

    bind core_ex core_ex_assert i_core_ex_assert (.*);

    // one random instruction with stall and flush kept rare
    task automatic drive_random();
        logic [31:0] r;
        word_t       a;
        word_t       b;
        alu_op_t     op;
        r  = $random(seed);
        a  = {$random(seed), $random(seed)};
        b  = (r[2:0] == 3'd0) ? a : {$random(seed), $random(seed)}; // equal operands now and then
        op = (r[18:16] < 3'd2) ? r[18:16] + 3'd2 : r[18:16]; // only the six real codes
        inst              <= $random(seed);
        a_data            <= a;
        b_data            <= b;
        pc4               <= {$random(seed), $random(seed)};
        stall             <= (r[6:3] == 4'd0);
        flush             <= (r[11:7] == 5'd0);
        d_valid           <= r[12];
        slt               <= (r[15:13] == 3'd0);
        alu_op            <= (r[15:13] == 3'd0) ? `ALU_SUB : op; // slt comes with a subtract
        alu_src2          <= (r[20:19] == 2'd3) ? `SRC2_REG : r[20:19];
        shifter_plus32    <= (r[22:21] == 2'd3) ? `PLUS32_NONE : r[22:21];
        cut_alu_out32     <= r[23];
        cut_shifter_out32 <= r[24];
        shift_right       <= r[25];
        alu_shifter_src   <= r[26];
        rd_src            <= r[27];
        r = $random(seed);
        {mem_read, word_we, byte_we, byte_load, write_enable} <= r[4:0];
        {mfc0, mtc0, eret, reserved_inst} <= r[8:5];
    endtask

    initial begin
        seed  = 32'hcbf0f626;
        reset = 1'b1;
        {stall, flush, d_valid, inst, a_data, b_data, pc4, alu_op, alu_src2, slt,
         cut_alu_out32, cut_shifter_out32, shift_right, shifter_plus32, alu_shifter_src,
         rd_src, mem_read, word_we, byte_we, byte_load, write_enable,
         mfc0, mtc0, eret, reserved_inst} = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        for (int i = 0; i < NUM_CYCLES; i++) begin
            drive_random();
            // a short reset in mid-run clears live data
            reset <= (i >= RESET_AT) && (i < RESET_AT + 2);
            @(posedge clock);
        end
        repeat (2) @(negedge clock); // last capture still has to be compared
        done = 1'b1;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (done) begin
            $display("%0d checks, %0d errors, %0d assertion failures",
                     checks, errors, i_core_ex.i_core_ex_assert.failures);
            if (errors == 0 && i_core_ex.i_core_ex_assert.failures == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end else if (cycles >= MAX_CYCLES) begin
            $display("Hang: stimulus did not complete within %0d cycles", MAX_CYCLES);
            $display("%0d checks, %0d errors, %0d assertion failures",
                     checks, errors, i_core_ex.i_core_ex_assert.failures);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

/* src.f */
+incdir+include
verilog/ex_pkg.sv
verilog/alu.sv
verilog/barrel_shifter.sv
verilog/core_ex.sv
dv/core_ex_assert.sv
dv/ex_checker.sv
dv/tb_core_ex.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_core_ex
FILELIST = src.f
SIMFLAGS = +verilator+error+limit+1000
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "test FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
